//--- src/mem_hub_pkg.sv
// Shared types and timing constants for the memory slot hub.
// A frame of FRAME_CYCLES clocks is split into slots of SLOT_CYCLES clocks,
// one memory access per slot. Modules refer to items here by scoped name.
`default_nettype none

package mem_hub_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int ADDR_W = 10;                  // word address into the store
  localparam int DATA_W = 16;                  // memory word

  ////////////////////
  // frame timing
  ////////////////////
  localparam int SLOT_CYCLES  = 4;             // clocks per slot
  localparam int FRAME_CYCLES = 16;            // clocks per frame, four slots
  localparam int SLOT_BITS    = $clog2(SLOT_CYCLES);
  localparam int FRAME_BITS   = $clog2(FRAME_CYCLES);

  // host request queue depth, also the credit count the host starts with
  localparam int HOST_CREDITS = 4;
  localparam int HQ_PTR_W     = $clog2(HOST_CREDITS);

  typedef logic [ADDR_W-1:0]              addr_t;       // word address
  typedef logic [DATA_W-1:0]              data_t;       // data word
  typedef logic [DATA_W/8-1:0]            byte_en_t;    // bit1 upper, bit0 lower, active high
  typedef logic [FRAME_BITS-1:0]          frame_cnt_t;  // cycle within frame
  typedef logic [FRAME_BITS-SLOT_BITS-1:0] slot_phase_t; // slot number within frame
  typedef logic [HQ_PTR_W-1:0]            hq_ptr_t;     // queue slot index
  typedef logic [$clog2(HOST_CREDITS+1)-1:0] hq_cnt_t;  // queue occupancy 0..depth

  // slot owner, also the sequencer state
  typedef enum logic [1:0] {
    SLOT_IDLE = 2'd0,                          // nobody on the memory port
    SLOT_CHIP = 2'd1,                          // chipset dma
    SLOT_CPU  = 2'd2,                          // main cpu
    SLOT_HOST = 2'd3                           // host controller via queue
  } slot_e;

endpackage

`default_nettype wire

//--- src/slot_timer.sv
// Free running frame counter on CLK_114.
// Gives the slot number, a pulse in the first cycle of each slot and the
// 7 MHz enable in the first cycle of slot 0. The first clk7_en follows
// the release of rst_n by one cycle, then recurs every frame.
`timescale 1ns/100ps
`default_nettype none

module slot_timer (
  input  logic                     CLK_114,
  input  logic                     rst_n,
  output mem_hub_pkg::slot_phase_t slot_phase,
  output logic                     slot_start,
  output logic                     clk7_en
);

  mem_hub_pkg::frame_cnt_t cnt;              // cycle within frame

  ////////////////////
  // frame counter
  ////////////////////
  // held at the last count in reset so the first cycle after it is count 0
  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      cnt <= mem_hub_pkg::frame_cnt_t'(mem_hub_pkg::FRAME_CYCLES - 1);
    end else if (cnt == mem_hub_pkg::frame_cnt_t'(mem_hub_pkg::FRAME_CYCLES - 1)) begin
      cnt <= '0;                             // frame wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////
  // decode
  ////////////////////
  // upper bits count slots, lower bits count cycles inside a slot
  assign slot_phase = cnt[mem_hub_pkg::FRAME_BITS-1:mem_hub_pkg::SLOT_BITS];
  assign slot_start = (cnt[mem_hub_pkg::SLOT_BITS-1:0] == '0);   // first cycle of slot
  assign clk7_en    = slot_start && (slot_phase == '0);           // first cycle of frame

endmodule

`default_nettype wire

//--- src/host_queue.sv
// Request queue for the host port with credit flow control.
// The host starts with HOST_CREDITS credits and spends one per host_valid
// pulse; each entry popped toward memory returns one credit through a
// host_credit pulse in the next cycle. The head entry is always visible.
`timescale 1ns/100ps
`default_nettype none

module host_queue (
  input  logic                  CLK_114,
  input  logic                  rst_n,
  input  logic                  host_valid,
  input  logic                  host_we,
  input  mem_hub_pkg::addr_t    host_addr,
  input  mem_hub_pkg::data_t    host_wdata,
  input  mem_hub_pkg::byte_en_t host_be,
  input  logic                  hq_pop,
  output logic                  hq_pending,
  output logic                  hq_we,
  output mem_hub_pkg::addr_t    hq_addr,
  output mem_hub_pkg::data_t    hq_wdata,
  output mem_hub_pkg::byte_en_t hq_be,
  output logic                  host_credit
);

  ////////////////////
  // storage
  ////////////////////
  logic                  q_we    [mem_hub_pkg::HOST_CREDITS];
  mem_hub_pkg::addr_t    q_addr  [mem_hub_pkg::HOST_CREDITS];
  mem_hub_pkg::data_t    q_wdata [mem_hub_pkg::HOST_CREDITS];
  mem_hub_pkg::byte_en_t q_be    [mem_hub_pkg::HOST_CREDITS];

  mem_hub_pkg::hq_ptr_t  wr_ptr;             // next free entry
  mem_hub_pkg::hq_ptr_t  rd_ptr;             // head entry
  mem_hub_pkg::hq_cnt_t  count;              // entries held

  // entries land unconditionally, credits keep the queue from overflow
  always_ff @(posedge CLK_114) begin
    if (host_valid) begin
      q_we[wr_ptr]    <= host_we;
      q_addr[wr_ptr]  <= host_addr;
      q_wdata[wr_ptr] <= host_wdata;
      q_be[wr_ptr]    <= host_be;
    end
  end

  ////////////////////
  // pointers and credits
  ////////////////////
  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      host_credit <= 1'b0;
    end else begin
      if (host_valid) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
      if (hq_pop)     rd_ptr <= rd_ptr + 1'b1;
      case ({host_valid, hq_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                           // none, or push and pop together
      endcase
      host_credit <= hq_pop;                 // one credit back per pop
    end
  end

  // head entry straight to the sequencer
  assign hq_pending = (count != '0);
  assign hq_we      = q_we[rd_ptr];
  assign hq_addr    = q_addr[rd_ptr];
  assign hq_wdata   = q_wdata[rd_ptr];
  assign hq_be      = q_be[rd_ptr];

endmodule

`default_nettype wire

//--- src/word_store.sv
// Single port word memory standing in for the SDRAM.
// Writes honour the byte enables; a read is registered and shows up one
// cycle after mem_en. A write cycle also returns the old contents.
`timescale 1ns/100ps
`default_nettype none

module word_store (
  input  logic                  CLK_114,
  input  logic                  mem_en,
  input  logic                  mem_we,
  input  mem_hub_pkg::addr_t    mem_addr,
  input  mem_hub_pkg::data_t    mem_wdata,
  input  mem_hub_pkg::byte_en_t mem_be,
  output mem_hub_pkg::data_t    mem_rdata
);

  ////////////////////
  // array
  ////////////////////
  mem_hub_pkg::data_t mem [2**mem_hub_pkg::ADDR_W];

  always_ff @(posedge CLK_114) begin
    if (mem_en) begin
      if (mem_we) begin
        // lane b covers bits b*8 .. b*8+7
        for (int b = 0; b < mem_hub_pkg::DATA_W / 8; b++) begin
          if (mem_be[b]) begin
            mem[mem_addr][b*8 +: 8] <= mem_wdata[b*8 +: 8];
          end
        end
      end
      mem_rdata <= mem[mem_addr];            // old word, read before write
    end
  end

endmodule

`default_nettype wire

//--- src/slot_sequencer.sv
// Slot arbiter and memory port driver.
// At each slot start an owner is chosen: slot 0 goes to the chipset, slots
// 1 and 3 favour the CPU, slot 2 favours the host, an idle favourite hands
// the slot on. The access goes out in the slot start cycle, read data is
// back one cycle later and the response pulse comes two cycles later.
`timescale 1ns/100ps
`default_nettype none

module slot_sequencer (
  input  logic                     CLK_114,
  input  logic                     rst_n,
  input  mem_hub_pkg::slot_phase_t slot_phase,
  input  logic                     slot_start,
  input  logic                     chip_req,
  input  logic                     chip_we,
  input  mem_hub_pkg::addr_t       chip_addr,
  input  mem_hub_pkg::data_t       chip_wdata,
  input  mem_hub_pkg::byte_en_t    chip_be,
  output logic                     chip_done,
  output mem_hub_pkg::data_t       chip_rdata,
  input  logic                     cpu_req,
  input  logic                     cpu_we,
  input  mem_hub_pkg::addr_t       cpu_addr,
  input  mem_hub_pkg::data_t       cpu_wdata,
  input  mem_hub_pkg::byte_en_t    cpu_be,
  output logic                     cpu_ack,
  output mem_hub_pkg::data_t       cpu_rdata,
  input  logic                     hq_pending,
  input  logic                     hq_we,
  input  mem_hub_pkg::addr_t       hq_addr,
  input  mem_hub_pkg::data_t       hq_wdata,
  input  mem_hub_pkg::byte_en_t    hq_be,
  output logic                     hq_pop,
  output logic                     host_rd_valid,
  output mem_hub_pkg::data_t       host_rdata,
  output logic                     mem_en,
  output logic                     mem_we,
  output mem_hub_pkg::addr_t       mem_addr,
  output mem_hub_pkg::data_t       mem_wdata,
  output mem_hub_pkg::byte_en_t    mem_be,
  input  mem_hub_pkg::data_t       mem_rdata
);

  mem_hub_pkg::slot_e grant;                 // owner picked this cycle
  mem_hub_pkg::slot_e state;                 // owner of the running slot
  mem_hub_pkg::slot_e own_q2;                // owner whose response is due
  logic               first_q;               // cycle after slot start
  logic               we_q1, we_q2;          // access direction down the pipe
  mem_hub_pkg::data_t rd_q;                  // captured read word

  ////////////////////
  // slot arbitration
  ////////////////////
  always_comb begin
    grant = mem_hub_pkg::SLOT_IDLE;
    if (slot_start) begin
      case (slot_phase)
        2'd0: begin                          // chipset slot, sampled at frame start
          if (chip_req)        grant = mem_hub_pkg::SLOT_CHIP;
          else if (cpu_req)    grant = mem_hub_pkg::SLOT_CPU;
          else if (hq_pending) grant = mem_hub_pkg::SLOT_HOST;
        end
        2'd2: begin                          // host first
          if (hq_pending)      grant = mem_hub_pkg::SLOT_HOST;
          else if (cpu_req)    grant = mem_hub_pkg::SLOT_CPU;
        end
        default: begin                       // slots 1 and 3, cpu first
          if (cpu_req)         grant = mem_hub_pkg::SLOT_CPU;
          else if (hq_pending) grant = mem_hub_pkg::SLOT_HOST;
        end
      endcase
    end
  end

  // memory port mux, live only in the slot start cycle
  always_comb begin
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_be    = '0;
    case (grant)
      mem_hub_pkg::SLOT_CHIP: begin
        mem_we = chip_we;  mem_addr = chip_addr;
        mem_wdata = chip_wdata;  mem_be = chip_be;
      end
      mem_hub_pkg::SLOT_CPU: begin
        mem_we = cpu_we;  mem_addr = cpu_addr;
        mem_wdata = cpu_wdata;  mem_be = cpu_be;
      end
      mem_hub_pkg::SLOT_HOST: begin
        mem_we = hq_we;  mem_addr = hq_addr;
        mem_wdata = hq_wdata;  mem_be = hq_be;
      end
      default: ;
    endcase
  end

  assign mem_en = (grant != mem_hub_pkg::SLOT_IDLE);
  assign hq_pop = (grant == mem_hub_pkg::SLOT_HOST);   // head leaves the queue now

  ////////////////////
  // owner pipeline
  ////////////////////
  // stage 1 is state while first_q, stage 2 is own_q2
  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      state   <= mem_hub_pkg::SLOT_IDLE;
      first_q <= 1'b0;
      own_q2  <= mem_hub_pkg::SLOT_IDLE;
    end else begin
      if (slot_start) state <= grant;      // held for the whole slot
      first_q <= slot_start;
      own_q2  <= first_q ? state : mem_hub_pkg::SLOT_IDLE;
    end
  end

  always_ff @(posedge CLK_114) begin
    we_q1 <= mem_we;
    we_q2 <= we_q1;
    if (first_q) rd_q <= mem_rdata;          // store word valid at s+1
  end

  // responses at s+2, one shared data word
  assign chip_done     = (own_q2 == mem_hub_pkg::SLOT_CHIP);
  assign cpu_ack       = (own_q2 == mem_hub_pkg::SLOT_CPU);
  assign host_rd_valid = (own_q2 == mem_hub_pkg::SLOT_HOST) && !we_q2;   // reads only
  assign chip_rdata    = rd_q;
  assign cpu_rdata     = rd_q;
  assign host_rdata    = rd_q;

endmodule

`default_nettype wire

//--- src/mem_hub_top.sv
// Top of the memory slot hub.
// Ties the frame timer, host queue, slot sequencer and word store together.
// The chipset, CPU and host ports and the 7 MHz enable are brought out.
`timescale 1ns/100ps
`default_nettype none

module mem_hub_top (
  input  logic                  CLK_114,
  input  logic                  rst_n,
  // chipset dma
  input  logic                  chip_req,
  input  logic                  chip_we,
  input  mem_hub_pkg::addr_t    chip_addr,
  input  mem_hub_pkg::data_t    chip_wdata,
  input  mem_hub_pkg::byte_en_t chip_be,
  output logic                  chip_done,
  output mem_hub_pkg::data_t    chip_rdata,
  // main cpu
  input  logic                  cpu_req,
  input  logic                  cpu_we,
  input  mem_hub_pkg::addr_t    cpu_addr,
  input  mem_hub_pkg::data_t    cpu_wdata,
  input  mem_hub_pkg::byte_en_t cpu_be,
  output logic                  cpu_ack,
  output mem_hub_pkg::data_t    cpu_rdata,
  // host controller, credit based
  input  logic                  host_valid,
  input  logic                  host_we,
  input  mem_hub_pkg::addr_t    host_addr,
  input  mem_hub_pkg::data_t    host_wdata,
  input  mem_hub_pkg::byte_en_t host_be,
  output logic                  host_credit,
  output logic                  host_rd_valid,
  output mem_hub_pkg::data_t    host_rdata,
  output logic                  clk7_en
);

  ////////////////////
  // internal nets
  ////////////////////
  mem_hub_pkg::slot_phase_t slot_phase;      // timer to sequencer
  logic                     slot_start;
  logic                     hq_pending;      // queue head
  logic                     hq_pop;
  logic                     hq_we;
  mem_hub_pkg::addr_t       hq_addr;
  mem_hub_pkg::data_t       hq_wdata;
  mem_hub_pkg::byte_en_t    hq_be;
  logic                     mem_en;          // sequencer to store
  logic                     mem_we;
  mem_hub_pkg::addr_t       mem_addr;
  mem_hub_pkg::data_t       mem_wdata;
  mem_hub_pkg::byte_en_t    mem_be;
  mem_hub_pkg::data_t       mem_rdata;

  slot_timer u_timer (
    .CLK_114    (CLK_114   ),
    .rst_n      (rst_n     ),
    .slot_phase (slot_phase),
    .slot_start (slot_start),
    .clk7_en    (clk7_en   )
  );

  host_queue u_hq (
    .CLK_114    (CLK_114    ),
    .rst_n      (rst_n      ),
    .host_valid (host_valid ),
    .host_we    (host_we    ),
    .host_addr  (host_addr  ),
    .host_wdata (host_wdata ),
    .host_be    (host_be    ),
    .hq_pop     (hq_pop     ),
    .hq_pending (hq_pending ),
    .hq_we      (hq_we      ),
    .hq_addr    (hq_addr    ),
    .hq_wdata   (hq_wdata   ),
    .hq_be      (hq_be      ),
    .host_credit(host_credit)
  );

  slot_sequencer u_seq (
    .CLK_114      (CLK_114      ),
    .rst_n        (rst_n        ),
    .slot_phase   (slot_phase   ),
    .slot_start   (slot_start   ),
    .chip_req     (chip_req     ),
    .chip_we      (chip_we      ),
    .chip_addr    (chip_addr    ),
    .chip_wdata   (chip_wdata   ),
    .chip_be      (chip_be      ),
    .chip_done    (chip_done    ),
    .chip_rdata   (chip_rdata   ),
    .cpu_req      (cpu_req      ),
    .cpu_we       (cpu_we       ),
    .cpu_addr     (cpu_addr     ),
    .cpu_wdata    (cpu_wdata    ),
    .cpu_be       (cpu_be       ),
    .cpu_ack      (cpu_ack      ),
    .cpu_rdata    (cpu_rdata    ),
    .hq_pending   (hq_pending   ),
    .hq_we        (hq_we        ),
    .hq_addr      (hq_addr      ),
    .hq_wdata     (hq_wdata     ),
    .hq_be        (hq_be        ),
    .hq_pop       (hq_pop       ),
    .host_rd_valid(host_rd_valid),
    .host_rdata   (host_rdata   ),
    .mem_en       (mem_en       ),
    .mem_we       (mem_we       ),
    .mem_addr     (mem_addr     ),
    .mem_wdata    (mem_wdata    ),
    .mem_be       (mem_be       ),
    .mem_rdata    (mem_rdata    )
  );

  word_store u_store (
    .CLK_114  (CLK_114  ),
    .mem_en   (mem_en   ),
    .mem_we   (mem_we   ),
    .mem_addr (mem_addr ),
    .mem_wdata(mem_wdata),
    .mem_be   (mem_be   ),
    .mem_rdata(mem_rdata)
  );

endmodule

`default_nettype wire

//--- verification/mem_hub_properties.sv
// Concurrent checks bound into mem_hub_top.
// Covers the clk7_en cadence, chipset response timing, the host credit
// bound and quiet response outputs after reset.
`timescale 1ns/100ps
`default_nettype none

module mem_hub_properties (
  input logic CLK_114,
  input logic rst_n,
  input logic clk7_en,
  input logic chip_req,
  input logic chip_done,
  input logic cpu_ack,
  input logic host_valid,
  input logic host_credit,
  input logic host_rd_valid
);

  int   gap;                                 // cycles since last clk7_en
  logic gap_ok;                              // first clk7_en seen
  int   outstanding;                         // host entries not yet credited

  always_ff @(posedge CLK_114) begin
    if (!rst_n) begin
      gap         <= 0;
      gap_ok      <= 1'b0;
      outstanding <= 0;
    end else begin
      if (clk7_en) begin
        gap    <= 1;
        gap_ok <= 1'b1;
      end else if (gap < 64) begin
        gap <= gap + 1;                      // saturates if cadence is lost
      end
      outstanding <= outstanding + int'(host_valid) - int'(host_credit);
    end
  end

  ////////////////////
  // frame cadence
  ////////////////////
  a_first_en: assert property (@(posedge CLK_114) $rose(rst_n) |=> clk7_en)
    else $error("no clk7_en in the first cycle after reset");

  a_cadence: assert property (@(posedge CLK_114) disable iff (!rst_n)
    (clk7_en && gap_ok) |-> gap == mem_hub_pkg::FRAME_CYCLES)
    else $error("clk7_en came %0d cycles after the previous one", gap);

  a_no_gap: assert property (@(posedge CLK_114) disable iff (!rst_n)
    gap_ok |-> gap <= mem_hub_pkg::FRAME_CYCLES)
    else $error("clk7_en missing");

  ////////////////////
  // chipset timing
  ////////////////////
  a_chip_lat: assert property (@(posedge CLK_114) disable iff (!rst_n)
    (clk7_en && chip_req) |-> ##2 chip_done)
    else $error("chip_done not 2 cycles after frame start");

  a_chip_src: assert property (@(posedge CLK_114) disable iff (!rst_n)
    chip_done |-> $past(clk7_en && chip_req, 2))
    else $error("chip_done without a sampled chipset request");

  ////////////////////
  // host credits and reset
  ////////////////////
  // a credit back with no entry in flight drives the count below zero
  a_credit_bound: assert property (@(posedge CLK_114) disable iff (!rst_n)
    outstanding >= 0 && outstanding <= mem_hub_pkg::HOST_CREDITS)
    else $error("%0d host entries outstanding", outstanding);

  a_valid_credit: assert property (@(posedge CLK_114) disable iff (!rst_n)
    host_valid |-> outstanding < mem_hub_pkg::HOST_CREDITS)
    else $error("host_valid with no credit held");

  a_quiet: assert property (@(posedge CLK_114)
    !rst_n |=> !(chip_done || cpu_ack || host_rd_valid || host_credit))
    else $error("response pulse right after reset");

endmodule

bind mem_hub_top mem_hub_properties props0 (
  .CLK_114      (CLK_114      ),
  .rst_n        (rst_n        ),
  .clk7_en      (clk7_en      ),
  .chip_req     (chip_req     ),
  .chip_done    (chip_done    ),
  .cpu_ack      (cpu_ack      ),
  .host_valid   (host_valid   ),
  .host_credit  (host_credit  ),
  .host_rd_valid(host_rd_valid)
);

`default_nettype wire

//--- verification/tb_mem_hub.sv
// Testbench for the memory slot hub.
// Drives the chipset, CPU and host ports, keeps a byte-masked reference
// memory updated in grant order and checks reads, latencies and credits.
// Built from all.f with tb_mem_hub as top module.
`timescale 1ns/100ps
`default_nettype none

module tb_mem_hub;

  logic                  CLK_114;
  logic                  rst_n;
  logic                  chip_req, chip_we, chip_done;
  logic                  cpu_req, cpu_we, cpu_ack;
  logic                  host_valid, host_we, host_credit, host_rd_valid;
  logic                  clk7_en;
  mem_hub_pkg::addr_t    chip_addr, cpu_addr, host_addr;
  mem_hub_pkg::data_t    chip_wdata, chip_rdata, cpu_wdata, cpu_rdata;
  mem_hub_pkg::data_t    host_wdata, host_rdata;
  mem_hub_pkg::byte_en_t chip_be, cpu_be, host_be;

  mem_hub_pkg::data_t    ref_mem [2**mem_hub_pkg::ADDR_W];   // reference words
  mem_hub_pkg::data_t    host_exp [$];                       // host reads in flight
  int errors = 0;
  int test_errs = 0;                         // errors at test start
  int passed = 0;
  int failed = 0;
  int cyc = 0;                               // posedge count
  int frame_cyc = 0;                         // cyc at last clk7_en
  int sent_cnt = 0;                          // host entries sent
  int credit_cnt = 0;                        // credits seen back

  mem_hub_top dut0 (.*);

  initial begin
    CLK_114 = 1'b0;
    forever #5 CLK_114 = ~CLK_114;           // 10 ns period
  end

  always @(posedge CLK_114) cyc <= cyc + 1;

  // watchdog, 6 tests of at most 200 frames each
  initial begin
    #(6 * 200 * mem_hub_pkg::FRAME_CYCLES * 10);
    $display("Watchdog expired before the tests completed");
    $display("Some tests failed");
    $finish;
  end

  ////////////////////
  // helpers
  ////////////////////
  task automatic report_fail(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_word(input string who, input mem_hub_pkg::data_t got,
                            input mem_hub_pkg::data_t exp);
    assert (got === exp)
      else report_fail($sformatf("%s read %h, expected %h", who, got, exp));
  endtask

  // bit 1 upper byte, bit 0 lower byte
  function automatic void apply_write(input mem_hub_pkg::addr_t a,
                                      input mem_hub_pkg::data_t d,
                                      input mem_hub_pkg::byte_en_t be);
    if (be[0]) ref_mem[a][7:0] = d[7:0];
    if (be[1]) ref_mem[a][15:8] = d[15:8];
  endfunction

  task automatic finish_test(input string name);
    if (errors == test_errs) begin
      passed++;
      $display("test %s done, no errors", name);
    end else begin
      failed++;
      $display("test %s done, %0d errors", name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  // frame marks, host credits and in-order host read data
  task automatic watch_outputs();
    forever begin
      @(negedge CLK_114);
      if (clk7_en) frame_cyc = cyc;
      if (host_credit) credit_cnt++;
      if (host_rd_valid) begin
        assert (host_exp.size() != 0) else report_fail("host read data with no read pending");
        if (host_exp.size() != 0) check_word("host", host_rdata, host_exp.pop_front());
      end
    end
  endtask

  ////////////////////
  // port drivers
  ////////////////////
  task automatic cpu_access(input logic we, input mem_hub_pkg::addr_t a,
                            input mem_hub_pkg::data_t d, input mem_hub_pkg::byte_en_t be,
                            output mem_hub_pkg::data_t q);
    int n;
    @(posedge CLK_114);
    cpu_req   <= 1'b1;                       // level request, held until ack
    cpu_we    <= we;
    cpu_addr  <= a;
    cpu_wdata <= d;
    cpu_be    <= be;
    n = -1;
    do begin
      @(negedge CLK_114);
      n++;
    end while (!cpu_ack);
    q = cpu_rdata;
    assert (n <= mem_hub_pkg::FRAME_CYCLES + 2)
      else report_fail($sformatf("cpu ack took %0d cycles", n));
    @(posedge CLK_114);
    cpu_req <= 1'b0;
    if (we) apply_write(a, d, be);
  endtask

  task automatic chip_access(input logic we, input mem_hub_pkg::addr_t a,
                             input mem_hub_pkg::data_t d, input mem_hub_pkg::byte_en_t be,
                             output mem_hub_pkg::data_t q);
    @(posedge CLK_114);
    chip_req   <= 1'b1;                      // stable until chip_done
    chip_we    <= we;
    chip_addr  <= a;
    chip_wdata <= d;
    chip_be    <= be;
    do begin
      @(negedge CLK_114);
    end while (!chip_done);
    q = chip_rdata;
    assert (cyc - frame_cyc == 2)
      else report_fail($sformatf("chip_done %0d cycles after frame start", cyc - frame_cyc));
    @(posedge CLK_114);
    chip_req <= 1'b0;
    if (we) apply_write(a, d, be);
  endtask

  // one pulse per credit held, stalls while all credits are out
  task automatic host_send(input logic we, input mem_hub_pkg::addr_t a,
                           input mem_hub_pkg::data_t d, input mem_hub_pkg::byte_en_t be);
    while (sent_cnt - credit_cnt >= mem_hub_pkg::HOST_CREDITS) @(negedge CLK_114);
    @(posedge CLK_114);
    host_valid <= 1'b1;
    host_we    <= we;
    host_addr  <= a;
    host_wdata <= d;
    host_be    <= be;
    sent_cnt++;
    if (we) apply_write(a, d, be);
    else host_exp.push_back(ref_mem[a]);
    @(posedge CLK_114);
    host_valid <= 1'b0;
  endtask

  task automatic host_drain();
    int n;
    n = 0;
    while ((credit_cnt != sent_cnt || host_exp.size() != 0) &&
           n < 4 * mem_hub_pkg::FRAME_CYCLES * mem_hub_pkg::HOST_CREDITS) begin
      @(negedge CLK_114);
      n++;
    end
    assert (credit_cnt == sent_cnt)
      else report_fail($sformatf("%0d host credits back for %0d sent", credit_cnt, sent_cnt));
    assert (host_exp.size() == 0) else report_fail("host read responses missing");
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic reset_cadence();
    int last;
    int seen;
    last = -1;
    seen = 0;
    repeat (3 * mem_hub_pkg::FRAME_CYCLES) begin
      @(negedge CLK_114);
      assert (!(chip_done || cpu_ack || host_rd_valid || host_credit))
        else report_fail("response pulse with no request");
      if (clk7_en) begin
        assert (last < 0 || cyc - last == mem_hub_pkg::FRAME_CYCLES)
          else report_fail($sformatf("clk7_en gap of %0d cycles", cyc - last));
        last = cyc;
        seen++;
      end
    end
    assert (seen >= 2) else report_fail("clk7_en missing");
  endtask

  task automatic cpu_test();
    mem_hub_pkg::addr_t a;
    mem_hub_pkg::data_t q;
    for (int i = 0; i < 8; i++) begin
      a = mem_hub_pkg::addr_t'($urandom) & 10'h0ff;
      cpu_access(1'b1, a, mem_hub_pkg::data_t'($urandom), 2'b11, q);
      cpu_access(1'b1, a, mem_hub_pkg::data_t'($urandom), mem_hub_pkg::byte_en_t'($urandom), q);
      cpu_access(1'b0, a, '0, '0, q);
      check_word("cpu", q, ref_mem[a]);
    end
  endtask

  task automatic chip_test();
    mem_hub_pkg::addr_t a;
    mem_hub_pkg::data_t q;
    for (int i = 0; i < 4; i++) begin
      a = mem_hub_pkg::addr_t'($urandom) & 10'h0ff;
      chip_access(1'b1, a, mem_hub_pkg::data_t'($urandom), 2'b11, q);
      chip_access(1'b0, a, '0, '0, q);
      check_word("chip", q, ref_mem[a]);
    end
  endtask

  // 8 entries per pass, twice the credits, so the host must wait
  task automatic host_test(input mem_hub_pkg::addr_t base);
    for (int i = 0; i < 8; i++)
      host_send(1'b1, mem_hub_pkg::addr_t'(base + i), mem_hub_pkg::data_t'($urandom), 2'b11);
    for (int i = 0; i < 8; i++)
      host_send(1'b1, mem_hub_pkg::addr_t'(base + i), mem_hub_pkg::data_t'($urandom),
                mem_hub_pkg::byte_en_t'($urandom));
    for (int i = 0; i < 8; i++)
      host_send(1'b0, mem_hub_pkg::addr_t'(base + i), '0, '0);
    host_drain();
  endtask

  // all masters write their own region, then read another master's region
  task automatic contention(input mem_hub_pkg::addr_t chip_base,
                            input mem_hub_pkg::addr_t cpu_base,
                            input mem_hub_pkg::addr_t host_base);
    mem_hub_pkg::data_t qc;
    mem_hub_pkg::data_t qu;
    fork
      for (int i = 0; i < 4; i++)
        chip_access(1'b1, mem_hub_pkg::addr_t'(chip_base + i),
                    mem_hub_pkg::data_t'($urandom), 2'b11, qc);
      for (int i = 0; i < 4; i++)
        cpu_access(1'b1, mem_hub_pkg::addr_t'(cpu_base + i),
                   mem_hub_pkg::data_t'($urandom), 2'b11, qu);
      for (int i = 0; i < 4; i++)
        host_send(1'b1, mem_hub_pkg::addr_t'(host_base + i),
                  mem_hub_pkg::data_t'($urandom), 2'b11);
    join
    host_drain();
    fork
      for (int i = 0; i < 4; i++) begin
        chip_access(1'b0, mem_hub_pkg::addr_t'(cpu_base + i), '0, '0, qc);
        check_word("chip", qc, ref_mem[mem_hub_pkg::addr_t'(cpu_base + i)]);
      end
      for (int i = 0; i < 4; i++) begin
        cpu_access(1'b0, mem_hub_pkg::addr_t'(host_base + i), '0, '0, qu);
        check_word("cpu", qu, ref_mem[mem_hub_pkg::addr_t'(host_base + i)]);
      end
      for (int i = 0; i < 4; i++)
        host_send(1'b0, mem_hub_pkg::addr_t'(chip_base + i), '0, '0);
    join
    host_drain();
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    rst_n      = 1'b0;
    chip_req   = 1'b0;
    chip_we    = 1'b0;
    chip_addr  = '0;
    chip_wdata = '0;
    chip_be    = '0;
    cpu_req    = 1'b0;
    cpu_we     = 1'b0;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    cpu_be     = '0;
    host_valid = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_be    = '0;
    void'($urandom(32'h79677d3c));           // single seed for the run
    fork
      watch_outputs();
    join_none
    repeat (4) @(posedge CLK_114);
    rst_n <= 1'b1;
    reset_cadence();
    finish_test("reset and cadence");
    cpu_test();
    finish_test("cpu write and read");
    chip_test();
    finish_test("chipset access");
    host_test(10'h380);
    finish_test("host credits");
    contention(10'h100, 10'h200, 10'h300);
    finish_test("contention round 1");
    contention(10'h140, 10'h240, 10'h340);
    finish_test("contention round 2");
    $display("tests run %0d, clean %0d, with errors %0d", passed + failed, passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/mem_hub_pkg.sv
src/slot_timer.sv
src/host_queue.sv
src/word_store.sv
src/slot_sequencer.sv
src/mem_hub_top.sv
verification/mem_hub_properties.sv
verification/tb_mem_hub.sv

//--- run.sh
#!/bin/sh
# Build the slot hub testbench with Verilator, run it and scan the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f all.f --top-module tb_mem_hub -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0
